//--- logic/frontend_pkg.sv
package frontend_pkg;

	// instruction memory map
	// reset pc and first word of the rom
	localparam logic [31:0] imem_base = 32'h06002000;
	localparam int imem_depth = 64;
	// word index width, enough for imem_depth words
	localparam int imem_aw = 6;
	// hex image path, relative to the run directory
	localparam imem_file = "logic/program.hex";

	// opcodes sit in bits 31..27 of every word
	localparam logic [4:0] op_nop = 5'b01111;
	// this opcode and everything above it is immediate format
	localparam logic [4:0] op_imm_lo = 5'b10000;
	// pc relative jump, immediate counts words
	localparam logic [4:0] op_jmp = 5'b11000;

	// canonical nop, remaining bits zero
	localparam logic [31:0] nop_word = {op_nop, 27'd0};

	// register format
	typedef struct packed {
		logic [4:0]  opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] funct;
	} r_fmt_t;

	// immediate format, imm is signed
	typedef struct packed {
		logic [4:0]  opcode;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [16:0] imm;
	} i_fmt_t;

	// same 32 bits seen through either format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_word_u;

	// word leaving fetch, tagged with its pc
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		instr_word_u instr;
	} fetch_pkt_t;

	// decode stage result
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		instr_word_u word;
		logic [4:0]  opcode;
		logic        is_imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic        is_jump;
	} decoded_t;

endpackage

//--- logic/instr_rom.sv
`timescale 1ns/1ps

module instr_rom (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [frontend_pkg::imem_aw-1:0] addr,
	output logic [31:0]                    data,
	output logic                           done
);

	import frontend_pkg::*;

	// program storage, filled once from the hex image
	logic [31:0] mem [imem_depth];

	initial begin
		$readmemh(imem_file, mem);
	end

	// synchronous read
	// addr is already the next pc, so data lines up with the pc register
	always_ff @(posedge clk) begin
		data <= mem[addr];
	end

	// ready from the first edge after reset on
	// before that the data register may hold a stale word
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= 1'b1;
		end
	end

endmodule

//--- logic/pc_fetch.sv
`timescale 1ns/1ps

module pc_fetch (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             stall,
	input  logic                             restore,
	input  logic [31:0]                      pc_before_int,
	input  logic                             redirect,
	input  logic [31:0]                      redirect_pc,
	input  logic                             use_cpu_injection,
	input  logic [31:0]                      cpu_injection,
	input  logic                             use_int_instr,
	input  logic [31:0]                      int_instr,
	input  logic [31:0]                      rom_data,
	input  logic                             rom_done,
	output logic [frontend_pkg::imem_aw-1:0] rom_addr,
	output frontend_pkg::fetch_pkt_t         fetch_pkt,
	output logic [31:0]                      current_pc
);

	import frontend_pkg::*;

	logic [31:0] pc;
	logic [31:0] pc_next;
	logic [31:0] pc_off;
	logic [31:0] instr_sel;

	// next pc priority
	// restore from interrupt beats a jump redirect, which beats stall
	// pc also waits until the rom has delivered its first word
	always_comb begin
		if (restore) begin
			pc_next = pc_before_int;
		end else if (redirect) begin
			pc_next = redirect_pc;
		end else if (stall || !rom_done) begin
			pc_next = pc;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			pc <= imem_base;
		end else begin
			pc <= pc_next;
		end
	end

	// byte offset into the rom, then drop the two byte bits
	assign pc_off = pc_next - imem_base;
	assign rom_addr = pc_off[imem_aw+1:2];

	// word source
	// cpu injection first, then the interrupt controller, then memory
	assign instr_sel = use_cpu_injection ? cpu_injection :
		(use_int_instr ? int_instr : rom_data);

	assign fetch_pkt.valid = rom_done;
	assign fetch_pkt.pc = pc;
	assign fetch_pkt.instr = instr_sel;

	// seen by the interrupt fsm
	assign current_pc = pc;

endmodule

//--- logic/fetch_decode_reg.sv
`timescale 1ns/1ps

module fetch_decode_reg (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     stall,
	input  logic                     flush,
	input  frontend_pkg::fetch_pkt_t in,
	output frontend_pkg::fetch_pkt_t out
);

	import frontend_pkg::*;

	logic        valid_q;
	logic [31:0] pc_q;
	instr_word_u instr_q;

	// valid is the only control bit here
	// a flushed slot is still valid, it just carries a nop
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b1;
		end else if (!stall) begin
			valid_q <= in.valid;
		end
	end

	// payload
	// flush keeps the pc of the wrong-path word but kills its instruction
	always_ff @(posedge clk) begin
		if (flush) begin
			pc_q <= in.pc;
			instr_q <= nop_word;
		end else if (!stall) begin
			pc_q <= in.pc;
			instr_q <= in.instr;
		end
	end

	assign out.valid = valid_q;
	assign out.pc = pc_q;
	assign out.instr = instr_q;

endmodule

//--- logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                     stall,
	input  frontend_pkg::fetch_pkt_t in,
	output frontend_pkg::decoded_t   dec,
	output logic                     redirect,
	output logic [31:0]              redirect_pc
);

	import frontend_pkg::*;

	logic [4:0]  opcode;
	logic        is_imm;
	logic        is_jump;
	logic [31:0] imm_ext;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	r_fmt_t      r_view;
	i_fmt_t      i_view;

	// both views of the same word
	assign r_view = in.instr.r;
	assign i_view = in.instr.i;

	// opcode position is common to both formats
	assign opcode = r_view.opcode;

	// upper half of the opcode space is immediate format
	assign is_imm = (opcode >= op_imm_lo);

	// field pick through the matching union member
	// rd and rs1 share their bits in both formats
	always_comb begin
		rd = r_view.rd;
		rs1 = r_view.rs1;
		if (is_imm) begin
			// no second source in immediate format
			rs2 = 5'd0;
			// 17 bit immediate, sign extended
			imm_ext = {{15{i_view.imm[16]}}, i_view.imm};
		end else begin
			rs2 = r_view.rs2;
			// funct stays in the raw word
			imm_ext = 32'd0;
		end
	end

	// pc relative jump, its opcode sits in the immediate range
	assign is_jump = (opcode == op_jmp);

	// target counts words relative to the jump itself
	assign redirect_pc = in.pc + {imm_ext[29:0], 2'b00};

	// only a real jump redirects
	// held back while stalled, so fetch never sees stall and redirect together
	assign redirect = in.valid && is_jump && !stall;

	always_comb begin
		dec.valid = in.valid;
		dec.pc = in.pc;
		dec.word = in.instr;
		dec.opcode = opcode;
		dec.is_imm = is_imm;
		dec.rd = rd;
		dec.rs1 = rs1;
		dec.rs2 = rs2;
		dec.imm = imm_ext;
		dec.is_jump = is_jump;
	end

endmodule

//--- logic/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   restore,
	input  logic [31:0]            pc_before_int,
	input  logic                   use_cpu_injection,
	input  logic [31:0]            cpu_injection,
	input  logic                   use_int_instr,
	input  logic [31:0]            int_instr,
	output frontend_pkg::decoded_t dec,
	output logic [31:0]            current_pc
);

	import frontend_pkg::*;

	// rom side
	logic [imem_aw-1:0] rom_addr;
	logic [31:0]        rom_data;
	logic               rom_done;

	// pipeline
	fetch_pkt_t  fetch_pkt;
	fetch_pkt_t  dec_pkt;

	// jump feedback, also flushes the fetch/decode register
	logic        redirect;
	logic [31:0] redirect_pc;

	instr_rom u_rom (
		.clk  (clk),
		.rst_n(rst_n),
		.addr (rom_addr),
		.data (rom_data),
		.done (rom_done)
	);

	pc_fetch u_fetch (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.restore          (restore),
		.pc_before_int    (pc_before_int),
		.redirect         (redirect),
		.redirect_pc      (redirect_pc),
		.use_cpu_injection(use_cpu_injection),
		.cpu_injection    (cpu_injection),
		.use_int_instr    (use_int_instr),
		.int_instr        (int_instr),
		.rom_data         (rom_data),
		.rom_done         (rom_done),
		.rom_addr         (rom_addr),
		.fetch_pkt        (fetch_pkt),
		.current_pc       (current_pc)
	);

	fetch_decode_reg u_fd_reg (
		.clk  (clk),
		.rst_n(rst_n),
		.stall(stall),
		.flush(redirect),
		.in   (fetch_pkt),
		.out  (dec_pkt)
	);

	instr_decode u_decode (
		.stall      (stall),
		.in         (dec_pkt),
		.dec        (dec),
		.redirect   (redirect),
		.redirect_pc(redirect_pc)
	);

endmodule

//--- verif/fetch_frontend_sva.sv
`timescale 1ns/1ps

module fetch_frontend_sva (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   restore,
	input  logic [31:0]            pc_before_int,
	input  logic                   use_cpu_injection,
	input  logic [31:0]            cpu_injection,
	input  logic                   use_int_instr,
	input  logic [31:0]            int_instr,
	input  logic                   redirect,
	input  logic                   rom_done,
	input  frontend_pkg::decoded_t dec,
	input  logic [31:0]            current_pc
);

	import frontend_pkg::*;

	// reference copy of the program image
	logic [31:0] img [imem_depth];
	// bumped by every failing assertion, watched by the testbench
	int          fail_count;
	logic [31:0] pc_off;
	logic [31:0] rom_word;
	logic [31:0] imm_sext;
	logic [31:0] jump_target;
	logic        word_is_imm;
	logic        word_is_jmp;

	initial begin
		fail_count = 0;
		$readmemh(imem_file, img);
	end

	// expected memory word for the decoded pc, byte offset over 4, modulo depth
	assign pc_off = dec.pc - imem_base;
	assign rom_word = img[(pc_off >> 2) % imem_depth];

	// format rule straight from the opcode bits
	assign word_is_imm = (dec.word[31:27] >= op_imm_lo);
	assign word_is_jmp = (dec.word[31:27] == op_jmp);
	// 17 bit immediate widened with its sign
	assign imm_sext = $signed(dec.word[16:0]);
	// jump target counts words from the jump itself
	assign jump_target = dec.pc + imm_sext * 32'd4;

	// nothing valid and no redirect before the rom is ready
	a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(rom_done) |-> !dec.valid && !redirect)
		else begin
			fail_count = fail_count + 1;
			$error("decode output became valid before the rom was ready");
		end

	a_first_pc: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && !$past(dec.valid) |-> dec.pc == imem_base)
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec.pc expected %h got %h", imem_base, $sampled(dec.pc));
		end

	// fetch pc shows up at decode one cycle later
	a_cur_pc: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && !$past(stall) |-> dec.pc == $past(current_pc))
		else begin
			fail_count = fail_count + 1;
			$error("Fail current_pc expected %h got %h", $sampled(dec.pc),
				$past(current_pc));
		end

	// plain sequential flow, pc steps by one word
	a_seq_pc: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && $past(dec.valid) && !$past(stall) && !$past(stall, 2) &&
		!$past(restore, 2) && !$past(redirect, 2)
		|-> dec.pc == $past(dec.pc) + 32'd4)
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec.pc expected %h got %h", $past(dec.pc) + 32'd4,
				$sampled(dec.pc));
		end

	// memory word matches the image when nothing overrides it
	a_seq_word: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && !$past(stall) && !$past(redirect) &&
		!$past(use_cpu_injection) && !$past(use_int_instr)
		|-> dec.word == rom_word)
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec.word expected %h got %h", $sampled(rom_word),
				$sampled(dec.word));
		end

	// back-pressure freezes the whole decode output
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$past(stall) |-> dec == $past(dec))
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec expected %h got %h", $past(dec), $sampled(dec));
		end

	// jump kills the wrong-path word, target follows one cycle later
	a_jump_flush: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && word_is_jmp && !stall && !restore
		|=> dec.valid && dec.word == nop_word
		##1 ($past(stall) || dec.pc == $past(jump_target, 2)))
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec after jump, dec.pc %h dec.word %h",
				$sampled(dec.pc), $sampled(dec.word));
		end

	a_cpu_inj: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && !$past(stall) && !$past(redirect) && $past(use_cpu_injection)
		|-> dec.word == $past(cpu_injection))
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec.word expected %h got %h", $past(cpu_injection),
				$sampled(dec.word));
		end

	// interrupt word only when the cpu is not injecting
	a_int_inj: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid && !$past(stall) && !$past(redirect) &&
		!$past(use_cpu_injection) && $past(use_int_instr)
		|-> dec.word == $past(int_instr))
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec.word expected %h got %h", $past(int_instr),
				$sampled(dec.word));
		end

	a_restore: assert property (@(posedge clk) disable iff (!rst_n)
		restore |-> ##2 ($past(stall) || dec.pc == $past(pc_before_int, 2)))
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec.pc expected %h got %h", $past(pc_before_int, 2),
				$sampled(dec.pc));
		end

	// field split follows the format of the opcode
	a_format: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid |-> dec.opcode == dec.word[31:27] && dec.is_imm == word_is_imm &&
		dec.is_jump == word_is_jmp && dec.rd == dec.word[26:22] &&
		dec.rs1 == dec.word[21:17] &&
		(word_is_imm ? (dec.rs2 == 5'd0 && dec.imm == imm_sext) :
		(dec.rs2 == dec.word[16:12] && dec.imm == 32'd0)))
		else begin
			fail_count = fail_count + 1;
			$error("Fail dec fields for word %h, opcode %h rd %h rs1 %h rs2 %h imm %h",
				$sampled(dec.word), $sampled(dec.opcode), $sampled(dec.rd),
				$sampled(dec.rs1), $sampled(dec.rs2), $sampled(dec.imm));
		end

endmodule

//--- verif/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend;

	import frontend_pkg::*;

	localparam int clk_period = 40;
	localparam int reset_cycles = 4;
	// idle cycles after reset so the first fetch is plain
	localparam int quiet_cycles = 4;
	localparam int stim_cycles = 400;
	localparam int drain_cycles = 6;
	localparam int margin_cycles = 50;

	logic        clk;
	logic        rst_n;
	logic        stall;
	logic        restore;
	logic [31:0] pc_before_int;
	logic        use_cpu_injection;
	logic [31:0] cpu_injection;
	logic        use_int_instr;
	logic [31:0] int_instr;
	decoded_t    dec;
	logic [31:0] current_pc;
	logic [31:0] rng_state;

	fetch_frontend dut0 (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.restore          (restore),
		.pc_before_int    (pc_before_int),
		.use_cpu_injection(use_cpu_injection),
		.cpu_injection    (cpu_injection),
		.use_int_instr    (use_int_instr),
		.int_instr        (int_instr),
		.dec              (dec),
		.current_pc       (current_pc)
	);

	// checker sees the top ports plus the jump feedback and rom ready
	bind fetch_frontend fetch_frontend_sva u_sva (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.restore          (restore),
		.pc_before_int    (pc_before_int),
		.use_cpu_injection(use_cpu_injection),
		.cpu_injection    (cpu_injection),
		.use_int_instr    (use_int_instr),
		.int_instr        (int_instr),
		.redirect         (redirect),
		.rom_done         (rom_done),
		.dec              (dec),
		.current_pc       (current_pc)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one cycle of random control pulses and injected words
	task automatic drive_random_inputs();
		logic [31:0] r;
		rng_state = xorshift32(rng_state);
		r = rng_state;
		stall <= (r[2:0] == 3'd0);
		use_cpu_injection <= (r[5:3] == 3'd0);
		restore <= (r[11:8] == 4'd0);
		// restore targets stay inside the rom
		pc_before_int <= imem_base + {24'd0, r[17:12], 2'b00};
		use_int_instr <= (r[20:18] == 3'd0);
		rng_state = xorshift32(rng_state);
		cpu_injection <= rng_state;
		rng_state = xorshift32(rng_state);
		int_instr <= rng_state;
	endtask

	task automatic drive_idle();
		stall <= 1'b0;
		restore <= 1'b0;
		use_cpu_injection <= 1'b0;
		use_int_instr <= 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// first failing assertion ends the run
	initial begin
		wait (dut0.u_sva.fail_count != 0);
		$display("CHECKS FAILED");
		$fatal(1, "assertion failure in the decode checker");
	end

	// watchdog sized from the stimulus length
	initial begin
		repeat (reset_cycles + quiet_cycles + stim_cycles + drain_cycles + margin_cycles)
			@(posedge clk);
		$display("CHECKS FAILED");
		$fatal(1, "timeout, stimulus did not complete");
	end

	initial begin
		rst_n = 1'b0;
		stall = 1'b0;
		restore = 1'b0;
		pc_before_int = imem_base;
		use_cpu_injection = 1'b0;
		cpu_injection = 32'd0;
		use_int_instr = 1'b0;
		int_instr = 32'd0;
		rng_state = 32'd26;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		repeat (quiet_cycles) @(posedge clk);
		for (int i = 0; i < stim_cycles; i++) begin
			drive_random_inputs();
			@(posedge clk);
		end
		drive_idle();
		repeat (drain_cycles) @(posedge clk);
		if (dut0.u_sva.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "assertion failures were recorded");
		end
	end

endmodule

//--- fetch_frontend.f
logic/frontend_pkg.sv
logic/instr_rom.sv
logic/pc_fetch.sv
logic/fetch_decode_reg.sv
logic/instr_decode.sv
logic/fetch_frontend.sv
verif/fetch_frontend_sva.sv
verif/tb_fetch_frontend.sv

//--- logic/program.hex
// one 32-bit instruction word per column, two words per line, index 0 first
// opcode in bits 31..27, c0xxxxxx words are relative jumps counted in words
08443000 80820005
10c41001 88a2fffe
78000000 18464002
90c60010 2108a003
98e80007 29086004
c0000004 31290005
a0a2001f 39420006
a8c3ffff 414a7007
78000000 b1060123
49488008 b9280042
c0000006 5162900a
80411234 596aa00b
88630fff 617cb00c
908a0001 698cc00d
98ac0100 71ded00e
a0ce0002 0801e00f
a8f01000 1023f010
78000000 b0120011
18450011 b8341fff
20671012 80560013
c0000002 28892014
88780015 30ab3016
909a0016 38cd4017
98bc0018 40ef5018
78000000 a0de0019
49116019 a8f0001a
5133701a b012001b
5955801b b834001c
6177901c 8056001d
6999a01d 8878001e
71bbb01e 909a001f
78000000 c001ffc1
